// ==== hdl/channel_mux_top.sv ====
/* Sample router top level with one clock and a synchronous active-high reset.
   Configuration and counter readback go through the AXI4-Lite port, see
   mux_cfg_regs for the response rules */
`timescale 1ns/1ps
`default_nettype none
`include "channel_mux_defines.svh"

module channel_mux_top
  import sample_pkg::*;
  import mux_cfg_pkg::*;
(
  input  wire                             data_clk,
  input  wire                             config_reset,

  // AXI4-Lite slave
  input  wire [`CM_AXIL_ADDR_WIDTH-1:0]   awaddr,
  input  wire                             awvalid,
  output wire                             awready,
  input  wire [`CM_AXIL_DATA_WIDTH-1:0]   wdata,
  input  wire [`CM_AXIL_DATA_WIDTH/8-1:0] wstrb,
  input  wire                             wvalid,
  output wire                             wready,
  output wire [1:0]                       bresp,
  output wire                             bvalid,
  input  wire                             bready,
  input  wire [`CM_AXIL_ADDR_WIDTH-1:0]   araddr,
  input  wire                             arvalid,
  output wire                             arready,
  output wire [`CM_AXIL_DATA_WIDTH-1:0]   rdata,
  output wire [1:0]                       rresp,
  output wire                             rvalid,
  input  wire                             rready,

  // Sample streams
  input  wire in_samples_t                data_in,
  input  wire [`CM_IN_CHANNELS-1:0]       data_in_valid,
  output wire out_samples_t               data_out,
  output wire [`CM_OUT_CHANNELS-1:0]      data_out_valid
);

  wire select_map_t                 select_map;
  wire [`CM_OUT_CHANNELS-1:0]       out_enable;
  wire                              count_clear;
  wire count_array_t                counts;

  //////////////////////////////////////////////////
  // Register bank
  //////////////////////////////////////////////////

  mux_cfg_regs i_mux_cfg_regs (
    .data_clk     (data_clk),
    .config_reset (config_reset),
    .awaddr       (awaddr),
    .awvalid      (awvalid),
    .awready      (awready),
    .wdata        (wdata),
    .wstrb        (wstrb),
    .wvalid       (wvalid),
    .wready       (wready),
    .bresp        (bresp),
    .bvalid       (bvalid),
    .bready       (bready),
    .araddr       (araddr),
    .arvalid      (arvalid),
    .arready      (arready),
    .rdata        (rdata),
    .rresp        (rresp),
    .rvalid       (rvalid),
    .rready       (rready),
    .counts       (counts),
    .select_map   (select_map),
    .out_enable   (out_enable),
    .count_clear  (count_clear)
  );

  //////////////////////////////////////////////////
  // Sample path
  //////////////////////////////////////////////////

  realtime_channel_mux i_realtime_channel_mux (
    .data_clk       (data_clk),
    .config_reset   (config_reset),
    .data_in        (data_in),
    .data_in_valid  (data_in_valid),
    .select_map     (select_map),
    .out_enable     (out_enable),
    .data_out       (data_out),
    .data_out_valid (data_out_valid)
  );

  // Counts what the mux delivers, read back through the register bank
  output_sample_counters i_output_sample_counters (
    .data_clk       (data_clk),
    .config_reset   (config_reset),
    .data_out_valid (data_out_valid),
    .count_clear    (count_clear),
    .counts         (counts)
  );

endmodule

`default_nettype wire

// ==== hdl/mux_cfg_pkg.sv ====
/* Types of the configuration register bank and its AXI4-Lite port.
   Only OKAY and SLVERR responses are ever produced */
`default_nettype none
`include "channel_mux_defines.svh"

package mux_cfg_pkg;

  // AXI4-Lite response codes used by the slave
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_t;

  // Target of one decoded bus address
  typedef enum logic [2:0] {
    REG_SELECT,
    REG_ENABLE,
    REG_CLEAR,
    REG_COUNT,
    REG_NONE
  } reg_sel_t;

  // Delivered sample counts, element n belongs to output n
  typedef logic [`CM_COUNT_WIDTH-1:0] count_t;
  typedef count_t [`CM_OUT_CHANNELS-1:0] count_array_t;

endpackage

`default_nettype wire

// ==== hdl/mux_cfg_regs.sv ====
/* AXI4-Lite slave, single beat only and one transaction of each kind in flight.
   Writes with all wstrb bits low are answered but change nothing; any other
   strobe writes the whole word. COUNT is read only, writes to it are ignored.
   Unmapped or unaligned addresses give SLVERR and read as zero */
`timescale 1ns/1ps
`default_nettype none
`include "channel_mux_defines.svh"

module mux_cfg_regs
  import sample_pkg::*;
  import mux_cfg_pkg::*;
(
  input  wire                            data_clk,
  input  wire                            config_reset,

  // AXI4-Lite slave
  input  wire [`CM_AXIL_ADDR_WIDTH-1:0]  awaddr,
  input  wire                            awvalid,
  output logic                           awready,
  input  wire [`CM_AXIL_DATA_WIDTH-1:0]  wdata,
  input  wire [`CM_AXIL_DATA_WIDTH/8-1:0] wstrb,
  input  wire                            wvalid,
  output logic                           wready,
  output axil_resp_t                     bresp,
  output logic                           bvalid,
  input  wire                            bready,
  input  wire [`CM_AXIL_ADDR_WIDTH-1:0]  araddr,
  input  wire                            arvalid,
  output logic                           arready,
  output logic [`CM_AXIL_DATA_WIDTH-1:0] rdata,
  output axil_resp_t                     rresp,
  output logic                           rvalid,
  input  wire                            rready,

  // Register bank side
  input  wire count_array_t              counts,
  output select_map_t                    select_map,
  output logic [`CM_OUT_CHANNELS-1:0]    out_enable,
  output logic                           count_clear
);

  localparam int IDX_BITS = $clog2(`CM_OUT_CHANNELS);
  localparam int COUNT_SPAN = 4 * `CM_OUT_CHANNELS;

  reg_sel_t                       wr_sel;
  reg_sel_t                       rd_sel;
  logic                           wr_accept;
  logic                           wr_load;
  logic                           rd_accept;
  logic [`CM_AXIL_ADDR_WIDTH-1:0] rd_offset;
  logic [IDX_BITS-1:0]            rd_cnt_idx;
  logic [`CM_AXIL_DATA_WIDTH-1:0] rd_value;

  // Maps a byte address to the register it hits
  function automatic reg_sel_t decode_addr(input logic [`CM_AXIL_ADDR_WIDTH-1:0] addr);
    reg_sel_t sel;
    sel = REG_NONE;
    if (addr == `CM_ADDR_SELECT) begin
      sel = REG_SELECT;
    end else if (addr == `CM_ADDR_ENABLE) begin
      sel = REG_ENABLE;
    end else if (addr == `CM_ADDR_CLEAR) begin
      sel = REG_CLEAR;
    end else if ((addr >= `CM_ADDR_COUNT_BASE) &&
                 (addr < `CM_ADDR_COUNT_BASE + COUNT_SPAN) &&
                 (addr[1:0] == 2'b00)) begin
      sel = REG_COUNT;
    end
    return sel;
  endfunction

  //////////////////////////////////////////////////
  // Write channel
  //////////////////////////////////////////////////

  // Address and data are taken together, and only once the last response is gone
  assign wr_accept = awvalid && wvalid && !bvalid;
  assign awready   = wr_accept;
  assign wready    = wr_accept;
  assign wr_sel    = decode_addr(awaddr);
  assign wr_load   = wr_accept && (wstrb != '0);

  always_ff @(posedge data_clk) begin
    if (config_reset) begin
      select_map  <= '0;
      out_enable  <= '0;
      count_clear <= 1'b0;
      bvalid      <= 1'b0;
    end else begin
      count_clear <= wr_load && (wr_sel == REG_CLEAR);  // Single-cycle pulse
      if (wr_load && (wr_sel == REG_SELECT)) begin
        select_map <= select_map_t'(wdata[$bits(select_map_t)-1:0]);
      end
      if (wr_load && (wr_sel == REG_ENABLE)) begin
        out_enable <= wdata[`CM_OUT_CHANNELS-1:0];
      end
      if (wr_accept) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge data_clk) begin
    if (wr_accept) begin
      bresp <= (wr_sel == REG_NONE) ? SLVERR : OKAY;
    end
  end

  //////////////////////////////////////////////////
  // Read channel
  //////////////////////////////////////////////////

  assign rd_accept  = arvalid && !rvalid;
  assign arready    = rd_accept;
  assign rd_sel     = decode_addr(araddr);
  assign rd_offset  = araddr - `CM_ADDR_COUNT_BASE;
  assign rd_cnt_idx = rd_offset[2 +: IDX_BITS];  // Word index inside the count block

  always_comb begin
    rd_value = '0;
    case (rd_sel)
      REG_SELECT: rd_value[$bits(select_map_t)-1:0] = select_map;
      REG_ENABLE: rd_value[`CM_OUT_CHANNELS-1:0]   = out_enable;
      REG_COUNT:  rd_value = counts[rd_cnt_idx];
      default:    rd_value = '0;  // CLEAR and unmapped read as zero
    endcase
  end

  always_ff @(posedge data_clk) begin
    if (config_reset) begin
      rvalid <= 1'b0;
    end else if (rd_accept) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // Counts are sampled on the accept edge
  always_ff @(posedge data_clk) begin
    if (rd_accept) begin
      rdata <= rd_value;
      rresp <= (rd_sel == REG_NONE) ? SLVERR : OKAY;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/output_sample_counters.sv ====
/* One wrapping counter per output, counting cycles with data_out_valid high.
   Clear wins over increment, so a sample in the clear cycle is not counted */
`timescale 1ns/1ps
`default_nettype none
`include "channel_mux_defines.svh"

module output_sample_counters
  import mux_cfg_pkg::*;
(
  input  wire                         data_clk,
  input  wire                         config_reset,
  input  wire [`CM_OUT_CHANNELS-1:0]  data_out_valid,
  input  wire                         count_clear,
  output count_array_t                counts
);

  //////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////

  always_ff @(posedge data_clk) begin
    if (config_reset) begin
      counts <= '0;
    end else if (count_clear) begin
      counts <= '0;
    end else begin
      for (int n = 0; n < `CM_OUT_CHANNELS; n++) begin
        if (data_out_valid[n]) begin
          counts[n] <= counts[n] + 1'b1;  // Rolls over to zero at the top
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/realtime_channel_mux.sv ====
/* Registered crossbar with one cycle of latency and no back-pressure.
   Any input may feed any number of outputs. A select change takes effect
   on the first edge after the register write */
`timescale 1ns/1ps
`default_nettype none
`include "channel_mux_defines.svh"

module realtime_channel_mux
  import sample_pkg::*;
(
  input  wire                         data_clk,
  input  wire                         config_reset,
  input  wire in_samples_t            data_in,
  input  wire [`CM_IN_CHANNELS-1:0]   data_in_valid,
  input  wire select_map_t            select_map,
  input  wire [`CM_OUT_CHANNELS-1:0]  out_enable,
  output out_samples_t                data_out,
  output logic [`CM_OUT_CHANNELS-1:0] data_out_valid
);

  //////////////////////////////////////////////////
  // Valid path
  //////////////////////////////////////////////////

  // A disabled output stays silent whatever its source does
  always_ff @(posedge data_clk) begin
    if (config_reset) begin
      data_out_valid <= '0;
    end else begin
      for (int n = 0; n < `CM_OUT_CHANNELS; n++) begin
        data_out_valid[n] <= data_in_valid[select_map[n]] && out_enable[n];
      end
    end
  end

  //////////////////////////////////////////////////
  // Data path
  //////////////////////////////////////////////////

  // Loads every cycle; consumers only look at it while valid is high
  always_ff @(posedge data_clk) begin
    for (int n = 0; n < `CM_OUT_CHANNELS; n++) begin
      data_out[n] <= data_in[select_map[n]];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/sample_pkg.sv ====
/* Types of the sample streams and of the output select fields.
   Sizes come from the shared defines header */
`default_nettype none
`include "channel_mux_defines.svh"

package sample_pkg;

  // One sample word
  typedef logic [`CM_DATA_WIDTH-1:0] sample_t;

  // All channels of one cycle, element n is channel n
  typedef sample_t [`CM_IN_CHANNELS-1:0]  in_samples_t;
  typedef sample_t [`CM_OUT_CHANNELS-1:0] out_samples_t;

  // Index of an input channel
  typedef logic [`CM_SELECT_BITS-1:0] select_t;

  // Field n drives output n; field 0 sits in the low bits of the SELECT word
  typedef select_t [`CM_OUT_CHANNELS-1:0] select_map_t;

endpackage

`default_nettype wire

// ==== include/channel_mux_defines.svh ====
/* Sizes and register map of the channel mux. CM_SELECT_BITS must equal
   log2 of CM_IN_CHANNELS, and the count block must fit below 0x100 */
`ifndef CHANNEL_MUX_DEFINES_SVH
`define CHANNEL_MUX_DEFINES_SVH

// Sample path
`define CM_DATA_WIDTH        16
`define CM_IN_CHANNELS       8
`define CM_OUT_CHANNELS      4
`define CM_SELECT_BITS       3

// AXI4-Lite port and counters
`define CM_AXIL_ADDR_WIDTH   8
`define CM_AXIL_DATA_WIDTH   32
`define CM_COUNT_WIDTH       32

// Byte addresses, count n sits at CM_ADDR_COUNT_BASE + 4*n
`define CM_ADDR_SELECT       8'h00
`define CM_ADDR_ENABLE       8'h04
`define CM_ADDR_CLEAR        8'h08
`define CM_ADDR_COUNT_BASE   8'h10

`endif

// ==== tb/channel_mux_assert.sv ====
/* Concurrent checks on the AXI4-Lite responses and the reset state of the
   sample outputs, bound into every channel_mux_top instance */
`timescale 1ns/1ps
`default_nettype none
`include "channel_mux_defines.svh"

module channel_mux_assert (
  input wire                        data_clk,
  input wire                        config_reset,
  input wire                        awready,
  input wire                        bvalid,
  input wire                        bready,
  input wire                        rvalid,
  input wire                        rready,
  input wire [`CM_OUT_CHANNELS-1:0] data_out_valid
);

  int failures = 0;  // Number of assertion failures so far

  // A response stays up until the master takes it
  assert property (@(posedge data_clk) disable iff (config_reset)
    (bvalid && !bready) |=> bvalid)
    else begin
      failures++;
      $error("bvalid dropped before bready");
    end

  assert property (@(posedge data_clk) disable iff (config_reset)
    (rvalid && !rready) |=> rvalid)
    else begin
      failures++;
      $error("rvalid dropped before rready");
    end

  assert property (@(posedge data_clk) disable iff (config_reset)
    bvalid |-> !awready)
    else begin
      failures++;
      $error("awready high while a write response is pending");
    end

  assert property (@(posedge data_clk)
    config_reset |=> (data_out_valid == '0))  // Sample outputs are silent out of reset
    else begin
      failures++;
      $error("data_out_valid not low after reset");
    end

endmodule

bind channel_mux_top channel_mux_assert i_channel_mux_assert (
  .data_clk       (data_clk),
  .config_reset   (config_reset),
  .awready        (awready),
  .bvalid         (bvalid),
  .bready         (bready),
  .rvalid         (rvalid),
  .rready         (rready),
  .data_out_valid (data_out_valid)
);

`default_nettype wire

// ==== tb/channel_mux_top_tb.sv ====
/* Table-driven testbench for channel_mux_top. Inputs change 2 ns after the
   rising edge; the sample stream is idle whenever the bus reconfigures */
`timescale 1ns/1ps
`default_nettype none
`include "channel_mux_defines.svh"

module channel_mux_top_tb
  import sample_pkg::*;
  import mux_cfg_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int HANDSHAKE_LIMIT = 20;
  localparam int NUM_CASES = 6;

  typedef struct packed {
    select_map_t sel;
    logic [3:0]  en;
    logic [15:0] cycles;
    logic [7:0]  density;  // Percent of cycles with an input valid
    logic        clear;
  } stream_case_t;

  // Select fields in octal, output 3 first
  localparam stream_case_t CASES [NUM_CASES] = '{
    '{12'o3210, 4'hF, 16'd40, 8'd100, 1'b0},
    '{12'o7654, 4'hF, 16'd40, 8'd70,  1'b1},
    '{12'o5555, 4'hF, 16'd30, 8'd50,  1'b1},
    '{12'o0000, 4'h0, 16'd20, 8'd100, 1'b0},
    '{12'o1607, 4'h5, 16'd40, 8'd80,  1'b1},
    '{12'o2323, 4'hA, 16'd30, 8'd60,  1'b0}
  };

  logic                               data_clk;
  logic                               config_reset;
  logic [`CM_AXIL_ADDR_WIDTH-1:0]     awaddr;
  logic                               awvalid;
  wire                                awready;
  logic [`CM_AXIL_DATA_WIDTH-1:0]     wdata;
  logic [`CM_AXIL_DATA_WIDTH/8-1:0]   wstrb;
  logic                               wvalid;
  wire                                wready;
  wire  [1:0]                         bresp;
  wire                                bvalid;
  logic                               bready;
  logic [`CM_AXIL_ADDR_WIDTH-1:0]     araddr;
  logic                               arvalid;
  wire                                arready;
  wire  [`CM_AXIL_DATA_WIDTH-1:0]     rdata;
  wire  [1:0]                         rresp;
  wire                                rvalid;
  logic                               rready;
  in_samples_t                        data_in;
  logic [`CM_IN_CHANNELS-1:0]         data_in_valid;
  out_samples_t                       data_out;
  wire  [`CM_OUT_CHANNELS-1:0]        data_out_valid;

  // Reference model state
  select_map_t sel_model;
  logic [3:0]  en_model;
  logic [31:0] count_model [`CM_OUT_CHANNELS];
  int          checks;
  int          errors;

  channel_mux_top i_channel_mux_top (.*);

  always #(CLK_PERIOD/2) data_clk = ~data_clk;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
    end
  endtask

  //////////////////////////////////////////////////
  // AXI4-Lite master
  //////////////////////////////////////////////////

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic [1:0] exp_resp);
    int waited;
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    waited  = 0;
    #1;
    while (!(awready && wready) && waited < HANDSHAKE_LIMIT) begin
      @(posedge data_clk);
      #3;
      waited++;
    end
    if (waited == HANDSHAKE_LIMIT) begin
      errors++;
      $display("Write to address 0x%h was never accepted", addr);
    end
    @(posedge data_clk);
    #2;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    waited  = 0;
    while (!bvalid && waited < HANDSHAKE_LIMIT) begin
      @(posedge data_clk);
      #2;
      waited++;
    end
    if (!bvalid) begin
      errors++;
      $display("Write to address 0x%h never got a response", addr);
    end
    check_value("bresp", bresp, exp_resp);
    bready = 1'b1;
    @(posedge data_clk);
    #2;
    bready = 1'b0;
  endtask

  task automatic axil_read_check(input logic [7:0] addr, input logic [31:0] exp_data,
                                 input logic [1:0] exp_resp);
    int waited;
    araddr  = addr;
    arvalid = 1'b1;
    waited  = 0;
    #1;
    while (!arready && waited < HANDSHAKE_LIMIT) begin
      @(posedge data_clk);
      #3;
      waited++;
    end
    if (waited == HANDSHAKE_LIMIT) begin
      errors++;
      $display("Read of address 0x%h was never accepted", addr);
    end
    @(posedge data_clk);
    #2;
    arvalid = 1'b0;
    waited  = 0;
    while (!rvalid && waited < HANDSHAKE_LIMIT) begin
      @(posedge data_clk);
      #2;
      waited++;
    end
    if (!rvalid) begin
      errors++;
      $display("Read of address 0x%h never got a response", addr);
    end
    check_value($sformatf("rdata@%h", addr), rdata, exp_data);
    check_value($sformatf("rresp@%h", addr), rresp, exp_resp);
    rready = 1'b1;
    @(posedge data_clk);
    #2;
    rready = 1'b0;
  endtask

  task automatic read_all_counts();
    for (int n = 0; n < `CM_OUT_CHANNELS; n++) begin
      axil_read_check(`CM_ADDR_COUNT_BASE + 4 * n, count_model[n], OKAY);
    end
  endtask

  //////////////////////////////////////////////////
  // Sample stream with reference model
  //////////////////////////////////////////////////

  // Outputs seen after edge k must match the inputs driven before edge k
  task automatic run_stream(input int unsigned cycles, input int unsigned density);
    in_samples_t                prev_in;
    logic [`CM_IN_CHANNELS-1:0] prev_valid;
    logic [3:0]                 exp_valid;
    select_t                    src;
    prev_in    = data_in;
    prev_valid = data_in_valid;
    for (int i = 0; i <= cycles; i++) begin
      @(posedge data_clk);
      #2;
      for (int n = 0; n < `CM_OUT_CHANNELS; n++) begin
        src          = sel_model[n];
        exp_valid[n] = prev_valid[src] && en_model[n];
      end
      check_value("data_out_valid", data_out_valid, exp_valid);
      for (int n = 0; n < `CM_OUT_CHANNELS; n++) begin
        if (exp_valid[n]) begin
          check_value($sformatf("data_out[%0d]", n), data_out[n], prev_in[sel_model[n]]);
          count_model[n]++;
        end
      end
      for (int c = 0; c < `CM_IN_CHANNELS; c++) begin
        data_in[c]       = $urandom;
        data_in_valid[c] = (i < cycles) && (($urandom % 100) < density);
      end
      prev_in    = data_in;
      prev_valid = data_in_valid;
    end
    repeat (2) begin  // Let the last count increment land
      @(posedge data_clk);
      #2;
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    int unsigned limit;
    limit = 400;
    for (int k = 0; k < NUM_CASES; k++) begin
      limit += CASES[k].cycles + 200;
    end
    #(limit * CLK_PERIOD);
    $display("Run timed out after %0d cycles before all cases finished", limit);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    int assert_fails;
    void'($urandom(32'h71719418));
    data_clk      = 1'b0;
    config_reset  = 1'b1;
    awaddr        = '0;
    awvalid       = 1'b0;
    wdata         = '0;
    wstrb         = '0;
    wvalid        = 1'b0;
    bready        = 1'b0;
    araddr        = '0;
    arvalid       = 1'b0;
    rready        = 1'b0;
    data_in       = '0;
    data_in_valid = '0;
    sel_model     = '0;
    en_model      = '0;
    checks        = 0;
    errors        = 0;
    for (int n = 0; n < `CM_OUT_CHANNELS; n++) begin
      count_model[n] = '0;
    end
    repeat (5) @(posedge data_clk);
    #2;
    config_reset = 1'b0;

    // Reset state of the register bank
    axil_read_check(`CM_ADDR_SELECT, 32'h0, OKAY);
    axil_read_check(`CM_ADDR_ENABLE, 32'h0, OKAY);
    axil_read_check(`CM_ADDR_CLEAR, 32'h0, OKAY);
    read_all_counts();

    for (int k = 0; k < NUM_CASES; k++) begin
      sel_model = CASES[k].sel;
      en_model  = CASES[k].en;
      axil_write(`CM_ADDR_SELECT, {20'h0, sel_model}, OKAY);
      axil_write(`CM_ADDR_ENABLE, {28'h0, en_model}, OKAY);
      axil_read_check(`CM_ADDR_SELECT, {20'h0, sel_model}, OKAY);
      axil_read_check(`CM_ADDR_ENABLE, {28'h0, en_model}, OKAY);
      if (CASES[k].clear) begin
        axil_write(`CM_ADDR_CLEAR, 32'h1, OKAY);
        for (int n = 0; n < `CM_OUT_CHANNELS; n++) begin
          count_model[n] = '0;
        end
        read_all_counts();
      end
      run_stream(CASES[k].cycles, CASES[k].density);
      read_all_counts();
      axil_read_check(`CM_ADDR_CLEAR, 32'h0, OKAY);  // Reads zero with live counts around
    end

    // Unmapped and unaligned addresses leave the bank alone
    axil_write(8'h0C, 32'hFFFF_FFFF, SLVERR);
    axil_write(8'h24, 32'hFFFF_FFFF, SLVERR);
    axil_read_check(8'h0C, 32'h0, SLVERR);
    axil_read_check(8'h11, 32'h0, SLVERR);
    axil_read_check(`CM_ADDR_SELECT, {20'h0, sel_model}, OKAY);
    axil_read_check(`CM_ADDR_ENABLE, {28'h0, en_model}, OKAY);
    read_all_counts();

    assert_fails = i_channel_mux_top.i_channel_mux_assert.failures;
    $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, assert_fails);
    if ((errors == 0) && (assert_fails == 0)) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
hdl/sample_pkg.sv
hdl/mux_cfg_pkg.sv
hdl/mux_cfg_regs.sv
hdl/realtime_channel_mux.sv
hdl/output_sample_counters.sv
hdl/channel_mux_top.sv
tb/channel_mux_assert.sv
tb/channel_mux_top_tb.sv
